//--- build.f
hw/core_pkg.sv
hw/instr_mem.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/core_ctrl.sv
hw/core_top.sv
test/tb_clock.sv
test/core_tb.sv

//--- hw/core_ctrl.sv
module core_ctrl
(
    input  logic                            clk,
    input  logic                            n_reset,
    input  core_pkg::net_packet_s           net_packet_i,
    input  logic                            bar_commit_i,
    input  logic [core_pkg::MASK_WIDTH-1:0] bar_value_i,
    input  logic                            wait_commit_i,
    input  logic                            exec_writes_i,
    output core_pkg::net_cmd_s              net_cmd_o,
    output logic                            stall_o,
    output core_pkg::state_e                state_o,
    output logic [core_pkg::MASK_WIDTH-1:0] barrier_o,
    output logic                            exception_o,
    output logic [core_pkg::MASK_WIDTH-1:0] barrier_mask_o,
    output logic [core_pkg::MASK_WIDTH-1:0] barrier_reg_o
);

    core_pkg::state_e                state_r;
    core_pkg::state_e                state_n;
    logic [core_pkg::MASK_WIDTH-1:0] barrier_r;
    logic [core_pkg::MASK_WIDTH-1:0] mask_r;
    logic                            exception_r;
    logic                            id_match;
    logic                            pc_write;
    logic                            bar_write;

    // Packet counts only for our ID and a real op
    assign id_match = (net_packet_i.ID == core_pkg::CORE_ID)
        && (net_packet_i.net_op != core_pkg::NET_NULL);
    assign pc_write = id_match && (net_packet_i.net_op == core_pkg::NET_PC);
    assign bar_write = id_match && (net_packet_i.net_op == core_pkg::NET_BAR);

    assign net_cmd_o = '{pc_write_idle: pc_write && (state_r == core_pkg::IDLE),
                         imem_write: id_match && (net_packet_i.net_op == core_pkg::NET_INSTR),
                         reg_write: id_match && (net_packet_i.net_op == core_pkg::NET_REG),
                         address: net_packet_i.net_addr,
                         data: net_packet_i.net_data};

    // Imem port busy, register port conflict, or not running
    assign stall_o = net_cmd_o.imem_write
        || (net_cmd_o.reg_write && exec_writes_i)
        || (state_r != core_pkg::RUN);

    always_comb
    begin
        state_n = state_r;
        case (state_r)
            core_pkg::IDLE:
                if (net_cmd_o.pc_write_idle)
                    state_n = core_pkg::RUN;
            core_pkg::RUN:
                if (wait_commit_i)
                    state_n = core_pkg::IDLE;
            default:
                state_n = state_r;
        endcase
        // Exception overrides everything, one edge after it is flagged
        if (exception_r)
            state_n = core_pkg::ERR;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r <= core_pkg::IDLE;
            barrier_r <= '0;
            mask_r <= '0;
            exception_r <= 1'b0;
        end
        else
        begin
            state_r <= state_n;
            // PC packet seeds the barrier, BAR updates it
            if (net_cmd_o.pc_write_idle)
                barrier_r <= net_packet_i.net_data[core_pkg::MASK_WIDTH-1:0];
            else if (bar_commit_i)
                barrier_r <= bar_value_i;
            if (bar_write && (state_r != core_pkg::ERR))
                mask_r <= net_packet_i.net_data[core_pkg::MASK_WIDTH-1:0];
            // Sticky, PC write outside IDLE
            if (pc_write && (state_r != core_pkg::IDLE))
                exception_r <= 1'b1;
        end
    end

    assign state_o = state_r;
    assign barrier_o = mask_r & barrier_r;
    assign exception_o = exception_r;
    assign barrier_mask_o = mask_r;
    assign barrier_reg_o = barrier_r;

    // BAR and WAIT from execute may only retire while running
    commit_in_run_a: assert property (@(posedge clk) disable iff (!n_reset)
        (bar_commit_i || wait_commit_i) |-> (state_r == core_pkg::RUN))
        else $error("Instruction committed outside RUN");

endmodule

//--- hw/core_pkg.sv
package core_pkg;

    // Core geometry
    localparam int IMEM_ADDR_WIDTH = 10;
    localparam int RF_ADDR_WIDTH = 5;
    localparam int DATA_WIDTH = 32;
    localparam int MASK_WIDTH = 8;

    // Network ID this core answers to
    localparam logic [9:0] CORE_ID = 10'd1;

    // Instruction opcodes, all-zero word decodes as NOP
    typedef enum logic [5:0] {
        NOP = 6'd0,
        ADDU, SUBU, AND, OR, MOV,
        BEQZ, BNEQZ, BLTZ, BGTZ,
        JALR, BAR, WAIT
    } opcode_e;

    // 16-bit instruction word
    typedef struct packed {
        opcode_e                  opcode;
        logic [RF_ADDR_WIDTH-1:0] rd;
        // Source register or signed branch offset
        logic [RF_ADDR_WIDTH-1:0] rs_imm;
    } instruction_s;

    typedef enum logic [2:0] {NET_NULL, NET_INSTR, NET_REG, NET_PC, NET_BAR} net_op_e;

    // One-cycle network command
    typedef struct packed {
        logic [9:0]                 ID;
        net_op_e                    net_op;
        logic [IMEM_ADDR_WIDTH-1:0] net_addr;
        logic [DATA_WIDTH-1:0]      net_data;
    } net_packet_s;

    typedef enum logic [1:0] {IDLE, RUN, ERR} state_e;

    typedef struct packed {
        logic [IMEM_ADDR_WIDTH-1:0] pc;
        state_e                     state;
        logic [MASK_WIDTH-1:0]      barrier_mask;
        logic [MASK_WIDTH-1:0]      barrier;
    } debug_s;

    // Fetch to decode
    typedef struct packed {
        instruction_s               instruction;
        logic [IMEM_ADDR_WIDTH-1:0] pc;
    } fetch_s;

    // Decode to execute
    typedef struct packed {
        instruction_s               instruction;
        logic [IMEM_ADDR_WIDTH-1:0] pc;
        logic [RF_ADDR_WIDTH-1:0]   rd_addr;
        logic [DATA_WIDTH-1:0]      rd_val;
        logic [DATA_WIDTH-1:0]      rs_val;
        logic                       writes_rf;
    } exec_s;

    // Network commands decoded for this core
    typedef struct packed {
        logic                       pc_write_idle;
        logic                       imem_write;
        logic                       reg_write;
        logic [IMEM_ADDR_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0]      data;
    } net_cmd_s;

endpackage

//--- hw/core_top.sv
module core_top
(
    input  logic                             clk,
    input  logic                             n_reset,
    input  core_pkg::net_packet_s            net_packet_i,
    output logic [core_pkg::MASK_WIDTH-1:0]  barrier_o,
    output logic                             exception_o,
    output core_pkg::debug_s                 debug_o
);

    core_pkg::net_cmd_s                      net_cmd;
    core_pkg::state_e                        state;
    core_pkg::fetch_s                        fetch;
    core_pkg::exec_s                         exec;
    logic                                    stall;
    logic [core_pkg::MASK_WIDTH-1:0]         barrier_mask;
    logic [core_pkg::MASK_WIDTH-1:0]         barrier_reg;
    logic [core_pkg::IMEM_ADDR_WIDTH-1:0]    pc;
    logic [core_pkg::IMEM_ADDR_WIDTH-1:0]    jump_target;
    logic [core_pkg::RF_ADDR_WIDTH-1:0]      rs_addr;
    logic [core_pkg::RF_ADDR_WIDTH-1:0]      rd_addr;
    logic [core_pkg::RF_ADDR_WIDTH-1:0]      wb_addr;
    logic [core_pkg::DATA_WIDTH-1:0]         rs_val;
    logic [core_pkg::DATA_WIDTH-1:0]         rd_val;
    logic [core_pkg::DATA_WIDTH-1:0]         wb_data;
    logic [core_pkg::MASK_WIDTH-1:0]         bar_value;
    logic                                    branch_taken;
    logic                                    jump;
    logic                                    wb_en;
    logic                                    bar_commit;
    logic                                    wait_commit;

    // Observation only
    assign debug_o = '{pc: pc, state: state, barrier_mask: barrier_mask, barrier: barrier_reg};

    core_ctrl i_ctrl (
        .clk(clk),
        .n_reset(n_reset),
        .net_packet_i(net_packet_i),
        .bar_commit_i(bar_commit),
        .bar_value_i(bar_value),
        .wait_commit_i(wait_commit),
        .exec_writes_i(exec.writes_rf),
        .net_cmd_o(net_cmd),
        .stall_o(stall),
        .state_o(state),
        .barrier_o(barrier_o),
        .exception_o(exception_o),
        .barrier_mask_o(barrier_mask),
        .barrier_reg_o(barrier_reg)
    );

    fetch_unit i_fetch (
        .clk(clk),
        .n_reset(n_reset),
        .net_cmd_i(net_cmd),
        .stall_i(stall),
        .branch_taken_i(branch_taken),
        .jump_i(jump),
        .jump_target_i(jump_target),
        .exec_instruction_i(exec.instruction),
        .fetch_o(fetch),
        .pc_o(pc)
    );

    decode_stage i_decode (
        .clk(clk),
        .n_reset(n_reset),
        .fetch_i(fetch),
        .stall_i(stall),
        .flush_i(branch_taken),
        .wb_en_i(wb_en),
        .wb_addr_i(wb_addr),
        .wb_data_i(wb_data),
        .rs_val_i(rs_val),
        .rd_val_i(rd_val),
        .rs_addr_o(rs_addr),
        .rd_addr_o(rd_addr),
        .exec_o(exec)
    );

    reg_file i_rf (
        .clk(clk),
        .rs_addr_i(rs_addr),
        .rd_addr_i(rd_addr),
        .w_addr_i(wb_addr),
        .wen_i(wb_en),
        .w_data_i(wb_data),
        .rs_val_o(rs_val),
        .rd_val_o(rd_val)
    );

    execute_stage i_exec (
        .exec_i(exec),
        .stall_i(stall),
        .net_cmd_i(net_cmd),
        .state_i(state),
        .branch_taken_o(branch_taken),
        .jump_o(jump),
        .jump_target_o(jump_target),
        .wb_en_o(wb_en),
        .wb_addr_o(wb_addr),
        .wb_data_o(wb_data),
        .bar_commit_o(bar_commit),
        .bar_value_o(bar_value),
        .wait_commit_o(wait_commit)
    );

endmodule

//--- hw/decode_stage.sv
module decode_stage
(
    input  logic                               clk,
    input  logic                               n_reset,
    input  core_pkg::fetch_s                   fetch_i,
    input  logic                               stall_i,
    input  logic                               flush_i,
    input  logic                               wb_en_i,
    input  logic [core_pkg::RF_ADDR_WIDTH-1:0] wb_addr_i,
    input  logic [core_pkg::DATA_WIDTH-1:0]    wb_data_i,
    input  logic [core_pkg::DATA_WIDTH-1:0]    rs_val_i,
    input  logic [core_pkg::DATA_WIDTH-1:0]    rd_val_i,
    output logic [core_pkg::RF_ADDR_WIDTH-1:0] rs_addr_o,
    output logic [core_pkg::RF_ADDR_WIDTH-1:0] rd_addr_o,
    output core_pkg::exec_s                    exec_o
);

    logic [core_pkg::DATA_WIDTH-1:0] rs_val;
    logic [core_pkg::DATA_WIDTH-1:0] rd_val;
    logic                            writes_rf;
    logic                            fwd_rs;
    logic                            fwd_rd;
    core_pkg::exec_s                 exec_r;

    assign rs_addr_o = fetch_i.instruction.rs_imm;
    assign rd_addr_o = fetch_i.instruction.rd;

    // Ops that produce a register result
    assign writes_rf = fetch_i.instruction.opcode inside {core_pkg::ADDU, core_pkg::SUBU,
        core_pkg::AND, core_pkg::OR, core_pkg::MOV, core_pkg::JALR};

    // Bypass the value being written back this cycle
    // r0 never forwards
    assign fwd_rs = wb_en_i && (wb_addr_i == rs_addr_o) && (rs_addr_o != '0);
    assign fwd_rd = wb_en_i && (wb_addr_i == rd_addr_o) && (rd_addr_o != '0);
    assign rs_val = fwd_rs ? wb_data_i : rs_val_i;
    assign rd_val = fwd_rd ? wb_data_i : rd_val_i;

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            exec_r <= '0;
        else if (!stall_i)
        begin
            // Taken branch squashes the instruction behind it
            if (flush_i)
                exec_r <= '0;
            else
                exec_r <= '{instruction: fetch_i.instruction,
                            pc: fetch_i.pc,
                            rd_addr: rd_addr_o,
                            rd_val: rd_val,
                            rs_val: rs_val,
                            writes_rf: writes_rf};
        end
    end

    assign exec_o = exec_r;

endmodule

//--- hw/execute_stage.sv
module execute_stage
(
    input  core_pkg::exec_s                      exec_i,
    input  logic                                 stall_i,
    input  core_pkg::net_cmd_s                   net_cmd_i,
    input  core_pkg::state_e                     state_i,
    output logic                                 branch_taken_o,
    output logic                                 jump_o,
    output logic [core_pkg::IMEM_ADDR_WIDTH-1:0] jump_target_o,
    output logic                                 wb_en_o,
    output logic [core_pkg::RF_ADDR_WIDTH-1:0]   wb_addr_o,
    output logic [core_pkg::DATA_WIDTH-1:0]      wb_data_o,
    output logic                                 bar_commit_o,
    output logic [core_pkg::MASK_WIDTH-1:0]      bar_value_o,
    output logic                                 wait_commit_o
);

    logic [core_pkg::DATA_WIDTH-1:0]             alu_result;
    logic [core_pkg::IMEM_ADDR_WIDTH-1:0]        pc_plus1;
    logic signed [core_pkg::IMEM_ADDR_WIDTH-1:0] offset;
    logic                                        branch_cond;
    logic                                        commit;
    core_pkg::opcode_e                           op;

    assign op = exec_i.instruction.opcode;
    assign pc_plus1 = exec_i.pc + 1'b1;
    // Sign-extend the 5-bit branch offset
    assign offset = $signed(exec_i.instruction.rs_imm);

    // Instruction retires only in an unstalled RUN cycle
    assign commit = !stall_i && (state_i == core_pkg::RUN);

    always_comb
    begin
        alu_result = '0;
        branch_cond = 1'b0;
        case (op)
            core_pkg::ADDU:  alu_result = exec_i.rd_val + exec_i.rs_val;
            core_pkg::SUBU:  alu_result = exec_i.rd_val - exec_i.rs_val;
            core_pkg::AND:   alu_result = exec_i.rd_val & exec_i.rs_val;
            core_pkg::OR:    alu_result = exec_i.rd_val | exec_i.rs_val;
            core_pkg::MOV:   alu_result = exec_i.rs_val;
            core_pkg::BAR:   alu_result = exec_i.rs_val;
            // Link address
            core_pkg::JALR:  alu_result = {{(core_pkg::DATA_WIDTH - core_pkg::IMEM_ADDR_WIDTH){1'b0}},
                                           pc_plus1};
            // Branches look at rd only
            core_pkg::BEQZ:  branch_cond = (exec_i.rd_val == '0);
            core_pkg::BNEQZ: branch_cond = (exec_i.rd_val != '0);
            core_pkg::BLTZ:  branch_cond = exec_i.rd_val[core_pkg::DATA_WIDTH-1];
            core_pkg::BGTZ:  branch_cond = !exec_i.rd_val[core_pkg::DATA_WIDTH-1]
                                           && (exec_i.rd_val != '0);
            default:         alu_result = '0;
        endcase
    end

    assign branch_taken_o = branch_cond && commit;
    assign jump_o = (op == core_pkg::JALR) && commit;
    assign jump_target_o = (op == core_pkg::JALR)
        ? exec_i.rs_val[core_pkg::IMEM_ADDR_WIDTH-1:0]
        : exec_i.pc + offset;

    // Network write wins the register port
    assign wb_en_o = net_cmd_i.reg_write || (exec_i.writes_rf && commit);
    assign wb_addr_o = net_cmd_i.reg_write
        ? net_cmd_i.address[core_pkg::RF_ADDR_WIDTH-1:0]
        : exec_i.rd_addr;
    assign wb_data_o = net_cmd_i.reg_write ? net_cmd_i.data : alu_result;

    assign bar_commit_o = (op == core_pkg::BAR) && commit;
    assign bar_value_o = alu_result[core_pkg::MASK_WIDTH-1:0];
    assign wait_commit_o = (op == core_pkg::WAIT) && commit;

endmodule

//--- hw/fetch_unit.sv
module fetch_unit
(
    input  logic                                 clk,
    input  logic                                 n_reset,
    input  core_pkg::net_cmd_s                   net_cmd_i,
    input  logic                                 stall_i,
    input  logic                                 branch_taken_i,
    input  logic                                 jump_i,
    input  logic [core_pkg::IMEM_ADDR_WIDTH-1:0] jump_target_i,
    input  core_pkg::instruction_s               exec_instruction_i,
    output core_pkg::fetch_s                     fetch_o,
    output logic [core_pkg::IMEM_ADDR_WIDTH-1:0] pc_o
);

    logic [core_pkg::IMEM_ADDR_WIDTH-1:0] pc_r;
    logic [core_pkg::IMEM_ADDR_WIDTH-1:0] pc_n;
    logic [core_pkg::IMEM_ADDR_WIDTH-1:0] imem_addr;
    core_pkg::instruction_s               imem_out;
    core_pkg::instruction_s               imem_wdata;
    core_pkg::fetch_s                     fetch_r;
    logic                                 pc_wen;
    logic                                 flush;

    // Network may load the PC even though IDLE holds the pipe stalled
    assign pc_wen = net_cmd_i.pc_write_idle || !stall_i;

    always_comb
    begin
        if (!pc_wen)
            pc_n = pc_r;
        else if (net_cmd_i.pc_write_idle)
            pc_n = net_cmd_i.address;
        else if (branch_taken_i || jump_i)
            pc_n = jump_target_i;
        else
            pc_n = pc_r + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            pc_r <= '0;
        else if (pc_wen)
            pc_r <= pc_n;
    end

    // Memory is addressed with next PC, so its output lines up with pc_r
    assign imem_addr = net_cmd_i.imem_write ? net_cmd_i.address : pc_n;
    assign imem_wdata = core_pkg::instruction_s'(net_cmd_i.data[15:0]);

    instr_mem i_imem (
        .clk(clk),
        .addr_i(imem_addr),
        .wen_i(net_cmd_i.imem_write),
        .instruction_i(imem_wdata),
        .instruction_o(imem_out)
    );

    // Kill the wrong-path slot after branches, jumps and WAIT
    assign flush = branch_taken_i
        || (fetch_r.instruction.opcode inside {core_pkg::JALR, core_pkg::WAIT})
        || (exec_instruction_i.opcode inside {core_pkg::JALR, core_pkg::WAIT});

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            fetch_r <= '0;
        else if (!stall_i)
        begin
            if (flush)
                fetch_r <= '0;
            else
                fetch_r <= '{instruction: imem_out, pc: pc_r};
        end
    end

    assign fetch_o = fetch_r;
    assign pc_o = pc_r;

    // A frozen PC would drop a redirect, so execute must not raise one in a stall
    redirect_stall_a: assert property (@(posedge clk) disable iff (!n_reset)
        stall_i |-> !(branch_taken_i || jump_i))
        else $error("Branch or jump requested while stalled");

endmodule

//--- hw/instr_mem.sv
module instr_mem
(
    input  logic                                 clk,
    input  logic [core_pkg::IMEM_ADDR_WIDTH-1:0] addr_i,
    input  logic                                 wen_i,
    input  core_pkg::instruction_s               instruction_i,
    output core_pkg::instruction_s               instruction_o
);

    core_pkg::instruction_s mem [2**core_pkg::IMEM_ADDR_WIDTH];

    // Write port for network loading, read is registered
    always_ff @(posedge clk)
    begin
        if (wen_i)
            mem[addr_i] <= instruction_i;
        instruction_o <= mem[addr_i];
    end

endmodule

//--- hw/reg_file.sv
module reg_file
(
    input  logic                               clk,
    input  logic [core_pkg::RF_ADDR_WIDTH-1:0] rs_addr_i,
    input  logic [core_pkg::RF_ADDR_WIDTH-1:0] rd_addr_i,
    input  logic [core_pkg::RF_ADDR_WIDTH-1:0] w_addr_i,
    input  logic                               wen_i,
    input  logic [core_pkg::DATA_WIDTH-1:0]    w_data_i,
    output logic [core_pkg::DATA_WIDTH-1:0]    rs_val_o,
    output logic [core_pkg::DATA_WIDTH-1:0]    rd_val_o
);

    logic [core_pkg::DATA_WIDTH-1:0] regs [2**core_pkg::RF_ADDR_WIDTH];

    always_ff @(posedge clk)
    begin
        if (wen_i)
            regs[w_addr_i] <= w_data_i;
    end

    // Register 0 is hardwired to zero
    assign rs_val_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rd_val_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule

//--- test/core_tb.sv
module core_tb;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 400;
    localparam int IDLE_TIMEOUT = 200;
    localparam int RESET_CYCLES = 5;
    localparam logic [31:0] SEED = 32'h82900a5c;

    logic                            clk;
    logic                            n_reset;
    core_pkg::net_packet_s           packet;
    logic [core_pkg::MASK_WIDTH-1:0] barrier;
    logic                            exception;
    core_pkg::debug_s                debug;

    // Failed checks overall, tests with at least one failure
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    // Mask value the core should hold
    logic [core_pkg::MASK_WIDTH-1:0] mask_exp = '0;
    // Name of the test in progress, for error lines
    string current_test = "";

    tb_clock i_clock (
        .clk_o(clk)
    );

    core_top i_dut (
        .clk(clk),
        .n_reset(n_reset),
        .net_packet_i(packet),
        .barrier_o(barrier),
        .exception_o(exception),
        .debug_o(debug)
    );

    function automatic core_pkg::net_packet_s make_packet(input logic [9:0] id,
        input core_pkg::net_op_e op, input logic [9:0] addr, input logic [31:0] data);
        return '{ID: id, net_op: op, net_addr: addr, net_data: data};
    endfunction

    function automatic core_pkg::instruction_s encode(input core_pkg::opcode_e op,
        input logic [4:0] rd, input logic [4:0] rs_imm);
        return '{opcode: op, rd: rd, rs_imm: rs_imm};
    endfunction

    // Packet is present for exactly one clock, then the port goes quiet
    task automatic send_packet(input core_pkg::net_packet_s p);
        @(posedge clk);
        packet <= p;
        @(posedge clk);
        packet <= '0;
    endtask

    task automatic load_instr(input logic [9:0] addr, input core_pkg::instruction_s ins);
        send_packet(make_packet(core_pkg::CORE_ID, core_pkg::NET_INSTR, addr, {16'h0000, ins}));
    endtask

    task automatic load_reg(input logic [4:0] addr, input logic [31:0] data);
        send_packet(make_packet(core_pkg::CORE_ID, core_pkg::NET_REG, {5'd0, addr}, data));
    endtask

    task automatic check_mask(input string name, input logic [core_pkg::MASK_WIDTH-1:0] exp,
        input logic [core_pkg::MASK_WIDTH-1:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s %s: expected %h, actual %h", current_test, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_state(input string name, input core_pkg::state_e exp,
        input core_pkg::state_e act);
        if (act !== exp)
        begin
            $display("ERROR %s %s: expected %0d, actual %0d", current_test, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERROR %s %s: expected %b, actual %b", current_test, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, input logic [core_pkg::IMEM_ADDR_WIDTH-1:0] exp,
        input logic [core_pkg::IMEM_ADDR_WIDTH-1:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s %s: expected %h, actual %h", current_test, name, exp, act);
            errors++;
        end
    endtask

    // Poll on the falling edge, where outputs are settled
    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((debug.state != core_pkg::IDLE) && (cycles < IDLE_TIMEOUT))
        begin
            @(negedge clk);
            cycles++;
        end
        if (debug.state != core_pkg::IDLE)
        begin
            $display("%s: core did not return to IDLE within %0d cycles", name, IDLE_TIMEOUT);
            errors++;
        end
    endtask

    // PC write starts the core and seeds the barrier
    task automatic run_program(input string name, input logic [9:0] addr,
        input logic [31:0] data);
        send_packet(make_packet(core_pkg::CORE_ID, core_pkg::NET_PC, addr, data));
        // One edge later the core runs from the new PC
        @(negedge clk);
        check_state("run_state", core_pkg::RUN, debug.state);
        check_pc("run_pc", addr, debug.pc);
        check_mask("run_barrier", data[7:0], debug.barrier);
        wait_idle(name);
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors)
            $display("%s: ok", name);
        else
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic test_reset();
        int start_errors;
        start_errors = errors;
        current_test = "test_reset";
        @(negedge clk);
        check_state("reset_state", core_pkg::IDLE, debug.state);
        check_mask("reset_barrier", '0, barrier);
        check_bit("reset_exception", 1'b0, exception);
        report_test("test_reset", start_errors);
    endtask

    task automatic test_mask_wait();
        int start_errors;
        logic [31:0] data;
        start_errors = errors;
        current_test = "test_mask_wait";
        data = 32'h0000_00A5;
        send_packet(make_packet(core_pkg::CORE_ID, core_pkg::NET_BAR, '0, 32'h0000_00FF));
        mask_exp = 8'hFF;
        @(negedge clk);
        check_mask("mask_set", mask_exp, debug.barrier_mask);
        // Another core's ID must be ignored
        send_packet(make_packet(10'd2, core_pkg::NET_BAR, '0, 32'h0000_000F));
        @(negedge clk);
        check_mask("mask_foreign", mask_exp, debug.barrier_mask);
        load_instr(10'h010, encode(core_pkg::WAIT, 5'd0, 5'd0));
        run_program("test_mask_wait", 10'h010, data);
        check_state("wait_state", core_pkg::IDLE, debug.state);
        check_mask("wait_barrier", mask_exp & data[7:0], barrier);
        report_test("test_mask_wait", start_errors);
    endtask

    task automatic test_forwarding();
        int start_errors;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        logic [31:0] diff;
        start_errors = errors;
        current_test = "test_forwarding";
        a = $urandom;
        b = $urandom;
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        // r1 = r1 + r2, then r2 = r2 - r1 needs the fresh r1
        load_instr(10'h020, encode(core_pkg::ADDU, 5'd1, 5'd2));
        load_instr(10'h021, encode(core_pkg::SUBU, 5'd2, 5'd1));
        load_instr(10'h022, encode(core_pkg::BAR, 5'd0, 5'd2));
        load_instr(10'h023, encode(core_pkg::WAIT, 5'd0, 5'd0));
        sum = a + b;
        diff = b - sum;
        run_program("test_forwarding", 10'h020, 32'h0);
        check_mask("forward_barrier", mask_exp & diff[7:0], barrier);
        report_test("test_forwarding", start_errors);
    endtask

    task automatic test_branches();
        int start_errors;
        start_errors = errors;
        current_test = "test_branches";
        load_reg(5'd6, 32'h0000_005A);
        load_reg(5'd7, 32'h0000_00C3);
        // BNEQZ on r0 falls through to the BAR of the right value
        load_instr(10'h040, encode(core_pkg::BNEQZ, 5'd0, 5'd2));
        load_instr(10'h041, encode(core_pkg::BAR, 5'd0, 5'd7));
        // BEQZ on r0 jumps over the BAR of the wrong value
        load_instr(10'h042, encode(core_pkg::BEQZ, 5'd0, 5'd2));
        load_instr(10'h043, encode(core_pkg::BAR, 5'd0, 5'd6));
        load_instr(10'h044, encode(core_pkg::WAIT, 5'd0, 5'd0));
        run_program("test_branches", 10'h040, 32'h0);
        check_mask("branch_barrier", mask_exp & 8'hC3, barrier);
        report_test("test_branches", start_errors);
    endtask

    task automatic test_jalr();
        int start_errors;
        logic [9:0] link;
        start_errors = errors;
        current_test = "test_jalr";
        load_reg(5'd5, 32'h0000_0080);
        load_instr(10'h060, encode(core_pkg::JALR, 5'd4, 5'd5));
        // Jump target reports the link register
        load_instr(10'h080, encode(core_pkg::BAR, 5'd0, 5'd4));
        load_instr(10'h081, encode(core_pkg::WAIT, 5'd0, 5'd0));
        link = 10'h060 + 10'd1;
        run_program("test_jalr", 10'h060, 32'h0);
        check_mask("jalr_barrier", mask_exp & link[7:0], barrier);
        report_test("test_jalr", start_errors);
    endtask

    task automatic test_exception();
        int start_errors;
        start_errors = errors;
        current_test = "test_exception";
        // Branch to itself keeps the core in RUN
        load_instr(10'h0A0, encode(core_pkg::BEQZ, 5'd0, 5'd0));
        send_packet(make_packet(core_pkg::CORE_ID, core_pkg::NET_PC, 10'h0A0, 32'h0));
        repeat (5)
            @(posedge clk);
        @(negedge clk);
        check_state("loop_state", core_pkg::RUN, debug.state);
        send_packet(make_packet(core_pkg::CORE_ID, core_pkg::NET_PC, 10'h0A0, 32'h0));
        // Exception on the packet edge, ERR one edge later
        @(negedge clk);
        check_bit("exception_set", 1'b1, exception);
        @(negedge clk);
        check_state("err_state", core_pkg::ERR, debug.state);
        send_packet(make_packet(core_pkg::CORE_ID, core_pkg::NET_BAR, '0, 32'h0000_000F));
        @(negedge clk);
        check_mask("err_mask", mask_exp, debug.barrier_mask);
        check_bit("exception_held", 1'b1, exception);
        report_test("test_exception", start_errors);
    endtask

    initial
    begin
        int seed_state;
        n_reset = 1'b0;
        packet = '0;
        seed_state = $urandom(SEED);
        repeat (RESET_CYCLES)
            @(posedge clk);
        n_reset <= 1'b1;
        test_reset();
        test_mask_wait();
        test_forwarding();
        test_branches();
        test_jalr();
        test_exception();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
            tests_run, tests_failed, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // Budget covers every test with margin
    initial
    begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog timeout, tests did not finish in %0d cycles",
            NUM_TESTS * CYCLES_PER_TEST);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- test/tb_clock.sv
module tb_clock
(
    output logic clk_o
);

    // Half of the 20 unit period
    localparam int HALF_PERIOD = 10;

    initial
    begin
        clk_o = 1'b0;
        forever
            #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule
